/* verilog/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define RESET_PC   32'h0000_0000
`define REG_COUNT  32

// opcode field, inst[31:26]
`define OP_SPECIAL 6'h00
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// funct field for SPECIAL, inst[5:0]
`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_NOR     6'h27
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

`endif

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;      // data value
    typedef logic [31:0] addr_t;      // byte address or pc
    typedef logic [4:0]  reg_addr_t;  // gpr index
    typedef logic [31:0] inst_t;      // instruction word

    // load and store use the adder for the address
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_LOAD,
        ALU_STORE
    } alu_op_e;

endpackage

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module fetch_stage
    import core_pkg::*;
(
    input  wire   clk_i,
    input  wire   rst_n_i,
    input  wire   stall_i,
    input  inst_t inst_i,

    output addr_t pc_o,
    output logic  fetch_en_o,
    output addr_t id_pc_o,
    output inst_t id_inst_o,
    output logic  id_valid_o
);

    assign fetch_en_o = ~stall_i;  // no fetch while IF/ID is held

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_o <= `RESET_PC;
        end else if (!stall_i) begin
            pc_o <= pc_o + 32'd4;
        end
    end

    // IF/ID register, empty in the first cycle after reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else if (!stall_i) begin
            id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            id_pc_o   <= pc_o;
            id_inst_o <= inst_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module reg_file
    import core_pkg::*;
(
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    input  wire       we_i,
    input  reg_addr_t wa_i,
    input  word_t     wd_i,

    output word_t     rd1_o,
    output word_t     rd2_o
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // writeback value bypassed to a read of the same register
    assign rd1_o = (ra1_i == '0)                  ? '0   :
                   (we_i && wa_i == ra1_i)        ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0)                  ? '0   :
                   (we_i && wa_i == ra2_i)        ? wd_i : regs[ra2_i];

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module decode_stage
    import core_pkg::*;
(
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  wire       bubble_i,
    input  addr_t     pc_i,
    input  inst_t     inst_i,
    input  wire       valid_i,
    input  word_t     rd1_i,
    input  word_t     rd2_i,
    input  wire       ex_wreg_i,
    input  wire       ex_is_load_i,
    input  reg_addr_t ex_wa_i,
    input  word_t     ex_res_i,
    input  wire       mem_wreg_i,
    input  reg_addr_t mem_wa_i,
    input  word_t     mem_res_i,

    output reg_addr_t ra1_o,
    output reg_addr_t ra2_o,
    output logic      stall_req_o,
    output addr_t     ex_pc_o,
    output alu_op_e   ex_op_o,
    output word_t     ex_opr1_o,
    output word_t     ex_opr2_o,
    output word_t     ex_store_data_o,
    output logic      ex_wreg_o,
    output reg_addr_t ex_wa_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      sext_imm;
    word_t      zext_imm;

    alu_op_e    dec_op;
    logic       dec_wreg;
    reg_addr_t  dec_wa;
    logic       use_rs;
    logic       use_rt;
    logic       shift_op;    // rt value goes to opr1
    logic       rt_as_opr2;
    word_t      imm_val;
    word_t      rs_val;
    word_t      rt_val;

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign funct    = inst_i[5:0];
    assign sext_imm = {{16{inst_i[15]}}, inst_i[15:0]};
    assign zext_imm = {16'h0, inst_i[15:0]};

    always_comb begin
        dec_op     = ALU_ADD;
        dec_wreg   = 1'b0;
        dec_wa     = rt;
        use_rs     = 1'b1;
        use_rt     = 1'b0;
        shift_op   = 1'b0;
        rt_as_opr2 = 1'b0;
        imm_val    = sext_imm;
        case (opcode)
            `OP_SPECIAL: begin
                dec_wa     = rd;
                dec_wreg   = 1'b1;
                use_rt     = 1'b1;
                rt_as_opr2 = 1'b1;
                case (funct)
                    `FN_ADDU: dec_op = ALU_ADD;
                    `FN_SUBU: dec_op = ALU_SUB;
                    `FN_AND:  dec_op = ALU_AND;
                    `FN_OR:   dec_op = ALU_OR;
                    `FN_XOR:  dec_op = ALU_XOR;
                    `FN_NOR:  dec_op = ALU_NOR;
                    `FN_SLT:  dec_op = ALU_SLT;
                    `FN_SLTU: dec_op = ALU_SLTU;
                    `FN_SLL, `FN_SRL: begin
                        dec_op     = (funct == `FN_SLL) ? ALU_SLL : ALU_SRL;
                        use_rs     = 1'b0;
                        shift_op   = 1'b1;
                        rt_as_opr2 = 1'b0;
                        imm_val    = {27'h0, inst_i[10:6]};
                        dec_wreg   = (inst_i != '0);  // all-zero word is the nop
                    end
                    default: begin
                        dec_wreg = 1'b0;
                        use_rs   = 1'b0;
                        use_rt   = 1'b0;
                    end
                endcase
            end
            `OP_ADDIU: begin dec_op = ALU_ADD; dec_wreg = 1'b1; end
            `OP_SLTI:  begin dec_op = ALU_SLT; dec_wreg = 1'b1; end
            `OP_ANDI:  begin dec_op = ALU_AND; dec_wreg = 1'b1; imm_val = zext_imm; end
            `OP_ORI:   begin dec_op = ALU_OR;  dec_wreg = 1'b1; imm_val = zext_imm; end
            `OP_XORI:  begin dec_op = ALU_XOR; dec_wreg = 1'b1; imm_val = zext_imm; end
            `OP_LUI: begin
                dec_op   = ALU_LUI;
                dec_wreg = 1'b1;
                use_rs   = 1'b0;
                imm_val  = zext_imm;
            end
            `OP_LW:    begin dec_op = ALU_LOAD; dec_wreg = 1'b1; end
            `OP_SW:    begin dec_op = ALU_STORE; use_rt = 1'b1; end
            default:   use_rs = 1'b0;  // unknown, treated as no-op
        endcase
    end

    assign ra1_o = rs;
    assign ra2_o = rt;

    // EX result first, then MEM, then the register file
    assign rs_val = (rs == '0)                       ? '0        :
                    (ex_wreg_i && ex_wa_i == rs)     ? ex_res_i  :
                    (mem_wreg_i && mem_wa_i == rs)   ? mem_res_i : rd1_i;
    assign rt_val = (rt == '0)                       ? '0        :
                    (ex_wreg_i && ex_wa_i == rt)     ? ex_res_i  :
                    (mem_wreg_i && mem_wa_i == rt)   ? mem_res_i : rd2_i;

    // load data not ready until the load reaches MEM
    assign stall_req_o = valid_i && ex_wreg_i && ex_is_load_i && ex_wa_i != '0 &&
                         ((use_rs && rs == ex_wa_i) || (use_rt && rt == ex_wa_i));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || bubble_i || !valid_i) begin
            ex_op_o   <= ALU_ADD;
            ex_wreg_o <= 1'b0;
        end else begin
            ex_op_o   <= dec_op;
            ex_wreg_o <= dec_wreg;
        end
        ex_pc_o         <= pc_i;
        ex_wa_o         <= dec_wa;
        ex_opr1_o       <= shift_op ? rt_val : rs_val;
        ex_opr2_o       <= rt_as_opr2 ? rt_val : imm_val;
        ex_store_data_o <= rt_val;
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  addr_t     pc_i,
    input  alu_op_e   op_i,
    input  word_t     opr1_i,
    input  word_t     opr2_i,
    input  word_t     store_data_i,
    input  wire       wreg_i,
    input  reg_addr_t wa_i,

    output word_t     res_o,
    output logic      is_load_o,
    output addr_t     mem_pc_o,
    output alu_op_e   mem_op_o,
    output word_t     mem_res_o,
    output word_t     mem_store_data_o,
    output logic      mem_wreg_o,
    output reg_addr_t mem_wa_o
);

    always_comb begin
        case (op_i)
            ALU_SUB:  res_o = opr1_i - opr2_i;
            ALU_AND:  res_o = opr1_i & opr2_i;
            ALU_OR:   res_o = opr1_i | opr2_i;
            ALU_XOR:  res_o = opr1_i ^ opr2_i;
            ALU_NOR:  res_o = ~(opr1_i | opr2_i);
            ALU_SLT:  res_o = {31'h0, $signed(opr1_i) < $signed(opr2_i)};
            ALU_SLTU: res_o = {31'h0, opr1_i < opr2_i};
            ALU_SLL:  res_o = opr1_i << opr2_i[4:0];
            ALU_SRL:  res_o = opr1_i >> opr2_i[4:0];
            ALU_LUI:  res_o = {opr2_i[15:0], 16'h0};
            default:  res_o = opr1_i + opr2_i;  // add, and load/store address
        endcase
    end

    assign is_load_o = (op_i == ALU_LOAD);

    // EX/MEM register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_op_o   <= ALU_ADD;
            mem_wreg_o <= 1'b0;
        end else begin
            mem_op_o   <= op_i;
            mem_wreg_o <= wreg_i;
        end
        mem_pc_o         <= pc_i;
        mem_res_o        <= res_o;
        mem_store_data_o <= store_data_i;
        mem_wa_o         <= wa_i;
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import core_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_n_i,
    input  addr_t      pc_i,
    input  alu_op_e    op_i,
    input  word_t      res_i,
    input  word_t      store_data_i,
    input  wire        wreg_i,
    input  reg_addr_t  wa_i,
    input  word_t      dbus_rdata_i,

    output logic       dbus_en_o,
    output addr_t      dbus_addr_o,
    output logic [3:0] dbus_wen_o,
    output word_t      dbus_wdata_o,
    output word_t      fwd_res_o,
    output logic       wb_valid_o,
    output addr_t      wb_pc_o,
    output logic       wb_wreg_o,
    output reg_addr_t  wb_wa_o,
    output word_t      wb_wd_o
);

    logic is_load;
    logic is_store;

    assign is_load  = (op_i == ALU_LOAD);
    assign is_store = (op_i == ALU_STORE);

    assign dbus_en_o    = is_load | is_store;
    assign dbus_addr_o  = res_i;
    assign dbus_wen_o   = is_store ? 4'hf : 4'h0;  // whole words only
    assign dbus_wdata_o = store_data_i;

    assign fwd_res_o = is_load ? dbus_rdata_i : res_i;

    // MEM/WB register, also the debug trace
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_wreg_o  <= 1'b0;
        end else begin
            wb_valid_o <= wreg_i | is_store;  // bubbles neither write nor store
            wb_wreg_o  <= wreg_i;
        end
        wb_pc_o <= pc_i;
        wb_wa_o <= wa_i;
        wb_wd_o <= fwd_res_o;
    end

endmodule

`default_nettype wire

/* verilog/pipeline_control.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeline_control (
    input  wire  clk_i,
    input  wire  rst_n_i,
    input  wire  stall_req_i,

    output logic stall_if_id_o,
    output logic bubble_ex_o
);

    logic stall_q;  // stalled in the previous cycle

    assign stall_if_id_o = stall_req_i & ~stall_q;
    assign bubble_ex_o   = stall_req_i & ~stall_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall_if_id_o;
        end
    end

endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_n_i,

    output logic       ibus_en_o,
    output addr_t      ibus_addr_o,
    input  inst_t      ibus_rdata_i,

    output logic       dbus_en_o,
    output addr_t      dbus_addr_o,
    input  word_t      dbus_rdata_i,
    output logic [3:0] dbus_wen_o,
    output word_t      dbus_wdata_o,

    output logic       debug_wb_valid_o,
    output addr_t      debug_wb_pc_o,
    output logic       debug_wb_wreg_o,
    output reg_addr_t  debug_wb_wraddr_o,
    output word_t      debug_wb_wrdata_o
);

    logic      stall_req;
    logic      stall_if_id;
    logic      bubble_ex;

    addr_t     id_pc;
    inst_t     id_inst;
    logic      id_valid;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    addr_t     ex_pc;
    alu_op_e   ex_op;
    word_t     ex_opr1;
    word_t     ex_opr2;
    word_t     ex_store_data;
    logic      ex_wreg;
    reg_addr_t ex_wa;
    word_t     ex_res;
    logic      ex_is_load;

    addr_t     mem_pc;
    alu_op_e   mem_op;
    word_t     mem_res;
    word_t     mem_store_data;
    logic      mem_wreg;
    reg_addr_t mem_wa;
    word_t     mem_fwd_res;

    fetch_stage fetch_stage_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_if_id),
        .inst_i     (ibus_rdata_i),
        .pc_o       (ibus_addr_o),
        .fetch_en_o (ibus_en_o),
        .id_pc_o    (id_pc),
        .id_inst_o  (id_inst),
        .id_valid_o (id_valid)
    );

    reg_file reg_file_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ra1_i   (ra1),
        .ra2_i   (ra2),
        .we_i    (debug_wb_wreg_o),
        .wa_i    (debug_wb_wraddr_o),
        .wd_i    (debug_wb_wrdata_o),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    decode_stage decode_stage_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .bubble_i        (bubble_ex),
        .pc_i            (id_pc),
        .inst_i          (id_inst),
        .valid_i         (id_valid),
        .rd1_i           (rd1),
        .rd2_i           (rd2),
        .ex_wreg_i       (ex_wreg),
        .ex_is_load_i    (ex_is_load),
        .ex_wa_i         (ex_wa),
        .ex_res_i        (ex_res),
        .mem_wreg_i      (mem_wreg),
        .mem_wa_i        (mem_wa),
        .mem_res_i       (mem_fwd_res),
        .ra1_o           (ra1),
        .ra2_o           (ra2),
        .stall_req_o     (stall_req),
        .ex_pc_o         (ex_pc),
        .ex_op_o         (ex_op),
        .ex_opr1_o       (ex_opr1),
        .ex_opr2_o       (ex_opr2),
        .ex_store_data_o (ex_store_data),
        .ex_wreg_o       (ex_wreg),
        .ex_wa_o         (ex_wa)
    );

    execute_stage execute_stage_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .pc_i             (ex_pc),
        .op_i             (ex_op),
        .opr1_i           (ex_opr1),
        .opr2_i           (ex_opr2),
        .store_data_i     (ex_store_data),
        .wreg_i           (ex_wreg),
        .wa_i             (ex_wa),
        .res_o            (ex_res),
        .is_load_o        (ex_is_load),
        .mem_pc_o         (mem_pc),
        .mem_op_o         (mem_op),
        .mem_res_o        (mem_res),
        .mem_store_data_o (mem_store_data),
        .mem_wreg_o       (mem_wreg),
        .mem_wa_o         (mem_wa)
    );

    mem_stage mem_stage_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_i         (mem_pc),
        .op_i         (mem_op),
        .res_i        (mem_res),
        .store_data_i (mem_store_data),
        .wreg_i       (mem_wreg),
        .wa_i         (mem_wa),
        .dbus_rdata_i (dbus_rdata_i),
        .dbus_en_o    (dbus_en_o),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_wen_o   (dbus_wen_o),
        .dbus_wdata_o (dbus_wdata_o),
        .fwd_res_o    (mem_fwd_res),
        .wb_valid_o   (debug_wb_valid_o),
        .wb_pc_o      (debug_wb_pc_o),
        .wb_wreg_o    (debug_wb_wreg_o),
        .wb_wa_o      (debug_wb_wraddr_o),
        .wb_wd_o      (debug_wb_wrdata_o)
    );

    pipeline_control pipeline_control_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_req_i   (stall_req),
        .stall_if_id_o (stall_if_id),
        .bubble_ex_o   (bubble_ex)
    );

endmodule

`default_nettype wire

/* verification/core_props.sv */
`timescale 1ns/100ps
`default_nettype none

module core_props
    import core_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_n_i,
    input  wire        stall_req_i,
    input  wire        stall_if_id_i,
    input  addr_t      pc_i,
    input  wire        dbus_en_i,
    input  wire  [3:0] dbus_wen_i,
    input  wire        wb_valid_i,
    input  wire        wb_wreg_i
);

    int fail_count = 0;  // failed assertions so far

    wb_wreg_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_wreg_i |-> wb_valid_i)
    else begin
        fail_count++;
        $error("trace register write without valid");
    end

    dbus_wen_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dbus_wen_i != 4'h0) |-> dbus_en_i)
    else begin
        fail_count++;
        $error("data bus write strobe without enable");
    end

    // the load has left EX one cycle later
    stall_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_req_i |=> !stall_req_i)
    else begin
        fail_count++;
        $error("stall request high on two consecutive cycles");
    end

    pc_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_if_id_i |=> $stable(pc_i))
    else begin
        fail_count++;
        $error("pc changed while fetch was stalled");
    end

endmodule

bind core_top core_props core_props_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stall_req_i   (stall_req),
    .stall_if_id_i (stall_if_id),
    .pc_i          (ibus_addr_o),
    .dbus_en_i     (dbus_en_o),
    .dbus_wen_i    (dbus_wen_o),
    .wb_valid_i    (debug_wb_valid_o),
    .wb_wreg_i     (debug_wb_wreg_o)
);

`default_nettype wire

/* verification/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module core_tb
    import core_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       ibus_en;
    addr_t      ibus_addr;
    inst_t      ibus_rdata;
    logic       dbus_en;
    addr_t      dbus_addr;
    word_t      dbus_rdata;
    logic [3:0] dbus_wen;
    word_t      dbus_wdata;
    logic       wb_valid;
    addr_t      wb_pc;
    logic       wb_wreg;
    reg_addr_t  wb_wraddr;
    word_t      wb_wrdata;

    inst_t      imem [64];
    word_t      dmem [64];

    // program table with one row per instruction
    inst_t      prog_inst [$];
    logic       prog_wreg [$];
    reg_addr_t  prog_wa [$];
    word_t      prog_wd [$];

    int         n_rows;
    int         n_writes;
    int         writes_seen;
    int         row_idx;
    int         cycle_count;
    int         cycle_limit;
    int         check_count;
    int         error_count;
    int         assert_fails;
    logic       timed_out;
    addr_t      last_pc;
    logic       trace_done;

    core_top core_top_inst (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .ibus_en_o         (ibus_en),
        .ibus_addr_o       (ibus_addr),
        .ibus_rdata_i      (ibus_rdata),
        .dbus_en_o         (dbus_en),
        .dbus_addr_o       (dbus_addr),
        .dbus_rdata_i      (dbus_rdata),
        .dbus_wen_o        (dbus_wen),
        .dbus_wdata_o      (dbus_wdata),
        .debug_wb_valid_o  (wb_valid),
        .debug_wb_pc_o     (wb_pc),
        .debug_wb_wreg_o   (wb_wreg),
        .debug_wb_wraddr_o (wb_wraddr),
        .debug_wb_wrdata_o (wb_wrdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // bus memories answer in the same cycle
    always @(negedge clk) begin
        if (ibus_addr[31:8] == 24'h0) begin
            ibus_rdata = imem[ibus_addr[7:2]];
        end else begin
            ibus_rdata = 32'h0;  // nop past the program
        end
        dbus_rdata = dmem[dbus_addr[7:2]];
    end

    always @(posedge clk) begin
        if (dbus_en) begin
            for (int b = 0; b < 4; b++) begin
                if (dbus_wen[b]) begin
                    dmem[dbus_addr[7:2]][8*b +: 8] <= dbus_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic inst_t r_type(input logic [5:0] funct, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic inst_t shift_type(input logic [5:0] funct, input reg_addr_t rd,
                                         input reg_addr_t rt, input logic [4:0] sa);
        return {`OP_SPECIAL, 5'd0, rt, rd, sa, funct};
    endfunction

    function automatic inst_t i_type(input logic [5:0] op, input reg_addr_t rt,
                                     input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // initial data word holds its byte address under a marker
    function automatic word_t fill_word(input int idx);
        return 32'hc0de_0000 | word_t'(idx << 2);
    endfunction

    function automatic word_t final_word(input int idx);
        case (idx)
            16:      return 32'h1234_5678;
            17:      return 32'h1234_567f;
            19:      return 32'hc0de_0048;
            20:      return 32'h1234_5678;
            default: return fill_word(idx);
        endcase
    endfunction

    task automatic add_row(input inst_t inst, input logic wreg, input reg_addr_t wa,
                           input word_t wd);
        prog_inst.push_back(inst);
        prog_wreg.push_back(wreg);
        prog_wa.push_back(wa);
        prog_wd.push_back(wd);
    endtask

    task automatic build_program();
        add_row(i_type(`OP_LUI,  5'd1, 5'd0, 16'h1234), 1'b1, 5'd1, 32'h1234_0000);
        add_row(i_type(`OP_ORI,  5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h1234_5678);
        add_row(i_type(`OP_LUI,  5'd2, 5'd0, 16'hffff), 1'b1, 5'd2, 32'hffff_0000);
        add_row(i_type(`OP_ORI,  5'd2, 5'd2, 16'h00f0), 1'b1, 5'd2, 32'hffff_00f0);
        add_row(r_type(`FN_ADDU, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h1233_5768);
        add_row(r_type(`FN_SUBU, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 32'h1235_5588);
        add_row(r_type(`FN_AND,  5'd5, 5'd1, 5'd2), 1'b1, 5'd5, 32'h1234_0070);
        add_row(r_type(`FN_OR,   5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 32'hffff_56f8);
        add_row(r_type(`FN_XOR,  5'd7, 5'd1, 5'd2), 1'b1, 5'd7, 32'hedcb_5688);
        add_row(r_type(`FN_NOR,  5'd8, 5'd1, 5'd2), 1'b1, 5'd8, 32'h0000_a907);
        add_row(r_type(`FN_SLT,  5'd9, 5'd2, 5'd1), 1'b1, 5'd9, 32'h0000_0001);
        add_row(r_type(`FN_SLTU, 5'd10, 5'd2, 5'd1), 1'b1, 5'd10, 32'h0000_0000);
        add_row(shift_type(`FN_SLL, 5'd11, 5'd1, 5'd4), 1'b1, 5'd11, 32'h2345_6780);
        add_row(shift_type(`FN_SRL, 5'd12, 5'd2, 5'd8), 1'b1, 5'd12, 32'h00ff_ff00);
        add_row(i_type(`OP_ADDIU, 5'd13, 5'd1, 16'hfff0), 1'b1, 5'd13, 32'h1234_5668);
        add_row(i_type(`OP_SLTI,  5'd14, 5'd2, 16'hffff), 1'b1, 5'd14, 32'h0000_0001);
        add_row(i_type(`OP_ANDI,  5'd15, 5'd6, 16'hf0ff), 1'b1, 5'd15, 32'h0000_50f8);
        add_row(i_type(`OP_ORI,   5'd16, 5'd0, 16'h8001), 1'b1, 5'd16, 32'h0000_8001);
        add_row(i_type(`OP_XORI,  5'd17, 5'd16, 16'hffff), 1'b1, 5'd17, 32'h0000_7ffe);
        add_row(i_type(`OP_ADDIU, 5'd18, 5'd16, 16'h8000), 1'b1, 5'd18, 32'h0000_0001);
        // dependency chain at distances 1, 2 and 3
        add_row(i_type(`OP_ADDIU, 5'd19, 5'd0, 16'h0007), 1'b1, 5'd19, 32'h0000_0007);
        add_row(r_type(`FN_ADDU, 5'd20, 5'd19, 5'd19), 1'b1, 5'd20, 32'h0000_000e);
        add_row(r_type(`FN_SUBU, 5'd21, 5'd20, 5'd19), 1'b1, 5'd21, 32'h0000_0007);
        add_row(r_type(`FN_ADDU, 5'd22, 5'd19, 5'd20), 1'b1, 5'd22, 32'h0000_0015);
        // memory accesses with three load-use stalls
        add_row(i_type(`OP_ADDIU, 5'd23, 5'd0, 16'h0040), 1'b1, 5'd23, 32'h0000_0040);
        add_row(i_type(`OP_SW, 5'd1, 5'd23, 16'h0000), 1'b0, 5'd0, 32'h0);
        add_row(i_type(`OP_LW, 5'd24, 5'd23, 16'h0000), 1'b1, 5'd24, 32'h1234_5678);
        add_row(r_type(`FN_ADDU, 5'd25, 5'd24, 5'd19), 1'b1, 5'd25, 32'h1234_567f);
        add_row(i_type(`OP_SW, 5'd25, 5'd23, 16'h0004), 1'b0, 5'd0, 32'h0);
        add_row(i_type(`OP_LW, 5'd26, 5'd23, 16'h0008), 1'b1, 5'd26, 32'hc0de_0048);
        add_row(i_type(`OP_SW, 5'd26, 5'd23, 16'h000c), 1'b0, 5'd0, 32'h0);
        add_row(i_type(`OP_LW, 5'd27, 5'd23, 16'h0004), 1'b1, 5'd27, 32'h1234_567f);
        add_row(shift_type(`FN_SRL, 5'd28, 5'd27, 5'd16), 1'b1, 5'd28, 32'h0000_1234);
        // register 0 is written in the trace but always reads zero
        add_row(i_type(`OP_ADDIU, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd0, 32'h1234_567d);
        add_row(r_type(`FN_ADDU, 5'd29, 5'd0, 5'd19), 1'b1, 5'd29, 32'h0000_0007);
        add_row(i_type(`OP_LUI, 5'd0, 5'd0, 16'hdead), 1'b1, 5'd0, 32'hdead_0000);
        add_row(r_type(`FN_ADDU, 5'd30, 5'd0, 5'd1), 1'b1, 5'd30, 32'h1234_5678);
        add_row(r_type(`FN_ADDU, 5'd31, 5'd0, 5'd0), 1'b1, 5'd31, 32'h0000_0000);
        add_row(i_type(`OP_SW, 5'd30, 5'd23, 16'h0010), 1'b0, 5'd0, 32'h0);
    endtask

    task automatic check_idle(input string phase);
        check_count++;
        if (wb_valid !== 1'b0 || dbus_en !== 1'b0) begin
            error_count++;
            $display("[ERROR] %0t: pipeline not idle %s, wb_valid %b dbus_en %b",
                     $time, phase, wb_valid, dbus_en);
        end
    endtask

    // compare one retired register write with the next writing row
    task automatic check_retire();
        while (row_idx < n_rows && !prog_wreg[row_idx]) begin
            row_idx++;
        end
        check_count++;
        if (row_idx >= n_rows) begin
            error_count++;
            $display("[ERROR] %0t: unexpected register write, pc %h wa %0d data %h",
                     $time, wb_pc, wb_wraddr, wb_wrdata);
        end else begin
            if (wb_pc !== addr_t'(row_idx << 2)) begin
                error_count++;
                $display("[ERROR] %0t: row %0d pc expected %h got %h",
                         $time, row_idx, addr_t'(row_idx << 2), wb_pc);
            end
            if (wb_wraddr !== prog_wa[row_idx]) begin
                error_count++;
                $display("[ERROR] %0t: row %0d destination expected %0d got %0d",
                         $time, row_idx, prog_wa[row_idx], wb_wraddr);
            end
            if (wb_wrdata !== prog_wd[row_idx]) begin
                error_count++;
                $display("[ERROR] %0t: row %0d data expected %h got %h",
                         $time, row_idx, prog_wd[row_idx], wb_wrdata);
            end
            row_idx++;
            writes_seen++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        ibus_rdata  = 32'h0;
        dbus_rdata  = 32'h0;
        check_count = 0;
        error_count = 0;
        writes_seen = 0;
        row_idx     = 0;
        timed_out   = 1'b0;
        trace_done  = 1'b0;

        build_program();
        n_rows   = prog_inst.size();
        n_writes = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < n_rows) ? prog_inst[i] : 32'h0;
            dmem[i] = fill_word(i);
            if (i < n_rows && prog_wreg[i]) begin
                n_writes++;
            end
        end
        cycle_limit = n_rows * 2 + 40;
        last_pc     = addr_t'((n_rows - 1) << 2);

        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            if (c > 0) begin
                check_idle("during reset");
            end
        end
        rst_n = 1'b1;
        check_count++;
        if (ibus_addr !== `RESET_PC || ibus_en !== 1'b1) begin
            error_count++;
            $display("[ERROR] %0t: first fetch expected %h enabled, got %h en %b",
                     $time, `RESET_PC, ibus_addr, ibus_en);
        end

        // run until the last row of the program shows up in the trace
        cycle_count = 0;
        while (!trace_done && cycle_count < cycle_limit) begin
            @(negedge clk);
            cycle_count++;
            if (cycle_count <= 2) begin
                check_idle("after reset");
            end
            if (wb_valid && wb_wreg) begin
                check_retire();
            end
            if (wb_valid === 1'b1 && wb_pc === last_pc) begin
                trace_done = 1'b1;
            end
        end
        if (!trace_done) begin
            timed_out = 1'b1;
            $display("timeout: the trace did not complete, %0d of %0d writes in %0d cycles",
                     writes_seen, n_writes, cycle_limit);
        end else begin
            check_count++;
            if (writes_seen != n_writes) begin
                error_count++;
                $display("[ERROR] %0t: register writes expected %0d got %0d",
                         $time, n_writes, writes_seen);
            end
            for (int i = 0; i < 64; i++) begin
                check_count++;
                if (dmem[i] !== final_word(i)) begin
                    error_count++;
                    $display("[ERROR] %0t: data word %0d expected %h got %h",
                             $time, i, final_word(i), dmem[i]);
                end
            end
        end

        assert_fails = core_top_inst.core_props_inst.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, timeout %0d",
                 check_count, error_count, assert_fails, timed_out);
        if (error_count == 0 && assert_fails == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mango_core.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/pipeline_control.sv
verilog/core_top.sv
verification/core_props.sv
verification/core_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build core_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f mango_core.f --top-module core_tb -Mdir obj_dir -o Vcore_tb
	./obj_dir/Vcore_tb +verilator+error+limit+100 | tee $(LOG)
	@if grep -qF '** PASS **' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
